/* project.f */
+incdir+src
src/eeprom_pkg.sv
src/eeprom_cmd_dispatch.sv
src/eeprom_serial_master.sv
src/eeprom_result_collect.sv
src/eeprom_array_ctrl.sv
testbench/eeprom_slave_model.sv
testbench/eeprom_properties.sv
testbench/tb_eeprom_array.sv

/* Makefile */
TOP = tb_eeprom_array
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -o sim_tb
	-./obj_dir/sim_tb > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "All checks passed" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* testbench/tb_eeprom_array.sv */
`timescale 1ns/1ps
`include "eeprom_defines.svh"

module tb_eeprom_array;
    import eeprom_pkg::*;

    localparam int CH          = `EE_CHANNELS;
    localparam int N_CMDS      = 48;
    localparam int WATCHDOG_NS = N_CMDS * 60 * 4 * `EE_PHASE * 40 + 50_000;

    logic                  CLK;
    logic                  RESET;
    logic                  wr;
    logic                  rd;
    logic [2:0]            chan;
    logic [`EE_ADDR_W-1:0] addr;
    logic [`EE_DATA_W-1:0] wdata;
    logic [CH-1:0]         sda_in;
    logic [CH-1:0]         scl;
    logic [CH-1:0]         sda_low;
    logic [CH-1:0]         s_low;
    logic [CH-1:0]         absent;
    logic                  reject;
    logic                  done;
    logic [2:0]            done_chan;
    ee_op_t                done_op;
    logic [`EE_DATA_W-1:0] rdata;
    logic                  error;

    logic [7:0]            shadow [CH][2048];
    logic [CH-1:0]         exp_valid;   // one command in flight per channel
    ee_op_t                exp_op   [CH];
    logic [7:0]            exp_data [CH];
    logic [CH-1:0]         exp_err;
    logic                  rej_exp;
    logic                  rej_next;
    logic [31:0]           rng;
    logic [10:0]           wa [CH];

    eeprom_array_ctrl dut_i (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .chan      (chan),
        .addr      (addr),
        .wdata     (wdata),
        .sda_in    (sda_in),
        .scl       (scl),
        .sda_low   (sda_low),
        .reject    (reject),
        .done      (done),
        .done_chan (done_chan),
        .done_op   (done_op),
        .rdata     (rdata),
        .error     (error)
    );

    for (genvar i = 0; i < CH; i++)
    begin : g_bus
        assign sda_in[i] = ~(sda_low[i] | s_low[i]);   // wired AND

        eeprom_slave_model #(.CHAN(i)) u_slave (
            .scl     (scl[i]),
            .sda     (sda_in[i]),
            .absent  (absent[i]),
            .sda_low (s_low[i])
        );
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // power-up contents of each device
    function automatic logic [7:0] fill_byte(input int c, input int a);
        return 8'(a) ^ 8'(a >> 3) ^ 8'(c * 90 + 17);
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic idle_cycle();
        @(posedge CLK);
        rej_exp  = rej_next;
        rej_next = 1'b0;
        wr <= 1'b0;
        rd <= 1'b0;
    endtask

    task automatic send_cmd(input ee_op_t o, input int c, input logic [10:0] a,
                            input logic [7:0] d);
        logic rej;
        @(posedge CLK);
        rej      = (c >= CH) || exp_valid[c];
        rej_exp  = rej_next;
        rej_next = rej;
        wr    <= (o == op_write);
        rd    <= (o == op_read);
        chan  <= 3'(c);
        addr  <= a;
        wdata <= d;
        if (!rej)
        begin
            exp_valid[c] = 1'b1;
            exp_op[c]    = o;
            exp_err[c]   = absent[c];
            exp_data[c]  = shadow[c][a];
            if (o == op_write && !absent[c])
                shadow[c][a] = d;
        end
    endtask

    task automatic wait_all();
        while (exp_valid != '0)
            idle_cycle();
    endtask

    task automatic check_result();
        int c;
        c = int'(done_chan);
        assert (c < CH && exp_valid[c])
            else fail_now("done arrived for a channel with no command in flight");
        assert (done_op === exp_op[c])
            else fail_now($sformatf("FAILED done_op expected %h got %h", exp_op[c], done_op));
        assert (error === exp_err[c])
            else fail_now($sformatf("FAILED error expected %h got %h", exp_err[c], error));
        if (exp_op[c] == op_read && !exp_err[c])
            assert (rdata === exp_data[c])
                else fail_now($sformatf("FAILED rdata expected %h got %h", exp_data[c], rdata));
        exp_valid[c] = 1'b0;
    endtask

    always @(negedge CLK)
    begin
        if (!RESET)
        begin
            assert (reject === rej_exp)
                else fail_now($sformatf("FAILED reject expected %h got %h", rej_exp, reject));
            if (done === 1'b1)
                check_result();
        end
    end

    initial
    begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    initial
    begin
        #(WATCHDOG_NS);
        fail_now("watchdog expired before all results arrived");
    end

    initial
    begin
        rng       = 32'hb114_718c;
        RESET     = 1'b1;
        wr        = 1'b0;
        rd        = 1'b0;
        chan      = '0;
        addr      = '0;
        wdata     = '0;
        absent    = '0;
        exp_valid = '0;
        exp_err   = '0;
        rej_exp   = 1'b0;
        rej_next  = 1'b0;
        for (int c = 0; c < CH; c++)
            for (int a = 0; a < 2048; a++)
                shadow[c][a] = fill_byte(c, a);
        repeat (2) @(posedge CLK);
        RESET <= 1'b0;
        idle_cycle();

        // channels started in back-to-back cycles each round
        for (int r = 0; r < 6; r++)
        begin
            for (int c = 0; c < CH; c++)
            begin
                rng   = xorshift(rng);
                wa[c] = 11'(rng);
                send_cmd(op_write, c, wa[c], 8'(rng >> 16));
            end
            wait_all();
            for (int c = 0; c < CH; c++)
                send_cmd(op_read, c, wa[c], 8'h00);
            wait_all();
            for (int c = 0; c < CH; c++)
            begin
                rng = xorshift(rng);
                send_cmd(op_read, c, 11'(rng >> 5), 8'h00);
            end
            wait_all();
        end

        // busy channel and out-of-range channel
        send_cmd(op_read, 0, 11'h123, 8'h00);
        idle_cycle();
        idle_cycle();
        send_cmd(op_write, 0, 11'h124, 8'h5a);
        idle_cycle();
        send_cmd(op_read, CH, 11'h010, 8'h00);
        idle_cycle();
        send_cmd(op_write, 5, 11'h011, 8'h33);
        wait_all();

        // one device absent
        absent[CH-1] <= 1'b1;
        idle_cycle();
        send_cmd(op_read, CH - 1, 11'h2a5, 8'h00);
        if (CH > 1)
            send_cmd(op_read, 0, wa[0], 8'h00);
        wait_all();
        send_cmd(op_write, CH - 1, 11'h2a5, 8'hc3);
        wait_all();
        absent[CH-1] <= 1'b0;
        idle_cycle();
        send_cmd(op_read, CH - 1, 11'h2a5, 8'h00);
        wait_all();

        repeat (4) idle_cycle();
        if (exp_valid == '0)
        begin
            $display("All checks passed");
            $finish;
        end
        else
            fail_now("commands still in flight at the end of the run");
    end

endmodule

/* testbench/eeprom_properties.sv */
`timescale 1ns/1ps
`include "eeprom_defines.svh"

module eeprom_properties (
    input logic                    CLK,
    input logic                    RESET,
    input logic [`EE_CHANNELS-1:0] scl,
    input logic [`EE_CHANNELS-1:0] sda_low,
    input logic [`EE_CHANNELS-1:0] sda_in,
    input logic                    reject,
    input logic                    done
);
    for (genvar i = 0; i < `EE_CHANNELS; i++)
    begin : g_bus
        logic scl_q;
        logic sda_q;
        logic edge_hi;   // sda moved while scl stayed high
        int   rises;     // scl rising edges since the last start or stop

        assign edge_hi = scl[i] && scl_q && (sda_in[i] != sda_q);

        always_ff @(posedge CLK)
        begin
            scl_q <= scl[i];
            sda_q <= sda_in[i];
            if (RESET)
                rises <= 0;
            else if (edge_hi)
                rises <= 0;
            else if (scl[i] && !scl_q)
                rises <= rises + 1;
        end

        // start and stop only at a frame boundary, never inside a byte
        assert property (@(posedge CLK) disable iff (RESET)
            edge_hi |-> (rises == 0 || rises % 9 == 1))
            else $error("sda changed under high scl inside a byte on bus %0d", i);

        // a stop leaves the bus idle
        assert property (@(posedge CLK) disable iff (RESET)
            ($fell(sda_low[i]) && scl[i] && $past(scl[i])) |=> (scl[i] && !sda_low[i]))
            else $error("sda rose under high scl outside a stop on bus %0d", i);
    end

    assert property (@(posedge CLK) RESET |=> !done)
        else $error("done pulsed during reset");

    assert property (@(posedge CLK) disable iff (RESET) reject |=> !reject)
        else $error("reject held longer than one cycle");

    assert property (@(posedge CLK) $fell(RESET) |-> (scl == '1 && sda_low == '0))
        else $error("bus not idle after reset");

endmodule

bind eeprom_array_ctrl eeprom_properties u_props (
    .CLK     (CLK),
    .RESET   (RESET),
    .scl     (scl),
    .sda_low (sda_low),
    .sda_in  (sda_in),
    .reject  (reject),
    .done    (done)
);

/* testbench/eeprom_slave_model.sv */
`timescale 1ns/1ps

module eeprom_slave_model #(
    parameter int CHAN = 0
) (
    input  logic scl,
    input  logic sda,
    input  logic absent,
    output logic sda_low
);
    logic [7:0]  mem [2048];
    logic [7:0]  shreg;
    logic [7:0]  txb;
    logic [10:0] ptr;
    logic        active;
    logic        sending;
    logic        go_send;
    logic        drv;
    int          cnt;
    int          phase;     // 0 control, 1 address, 2 data

    initial
    begin
        active  = 1'b0;
        sending = 1'b0;
        go_send = 1'b0;
        drv     = 1'b0;
        cnt     = 0;
        phase   = 0;
        ptr     = '0;
        for (int a = 0; a < 2048; a++)
            mem[a] = 8'(a) ^ 8'(a >> 3) ^ 8'(CHAN * 90 + 17);
    end

    assign sda_low = drv && !absent;

    // start or repeated start
    always @(negedge sda)
    begin
        if (scl === 1'b1 && !absent)
        begin
            active  = 1'b1;
            sending = 1'b0;
            go_send = 1'b0;
            drv     = 1'b0;
            cnt     = 0;
            phase   = 0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            active = 1'b0;   // stop
            drv    = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (active)
        begin
            if (sending && cnt == 8 && sda === 1'b1)
                active = 1'b0;   // master nack ends the read
            else if (!sending && cnt < 8)
                shreg = {shreg[6:0], sda};
            cnt++;
        end
    end

    always @(negedge scl)
    begin
        if (active)
        begin
            if (sending)
                drv = (cnt < 8) ? !txb[7 - cnt] : 1'b0;
            else if (cnt == 8)
            begin
                case (phase)
                    0:
                    begin
                        if (shreg[7:4] == 4'b1010)
                        begin
                            ptr[10:8] = shreg[3:1];
                            drv       = 1'b1;
                            if (shreg[0])
                                go_send = 1'b1;
                            else
                                phase = 1;
                        end
                        else
                            active = 1'b0;
                    end
                    1:
                    begin
                        ptr[7:0] = shreg;
                        phase    = 2;
                        drv      = 1'b1;
                    end
                    default:
                    begin
                        mem[ptr] = shreg;
                        drv      = 1'b1;
                    end
                endcase
            end
            else if (cnt == 9)
            begin
                drv = 1'b0;
                cnt = 0;
                if (go_send)
                begin
                    sending = 1'b1;
                    txb     = mem[ptr];
                    drv     = !txb[7];
                end
            end
        end
    end

endmodule

/* src/eeprom_array_ctrl.sv */
`timescale 1ns/1ps
`include "eeprom_defines.svh"

module eeprom_array_ctrl (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    wr,
    input  logic                    rd,
    input  logic [2:0]              chan,
    input  logic [`EE_ADDR_W-1:0]   addr,
    input  logic [`EE_DATA_W-1:0]   wdata,
    input  logic [`EE_CHANNELS-1:0] sda_in,
    output logic [`EE_CHANNELS-1:0] scl,
    output logic [`EE_CHANNELS-1:0] sda_low,
    output logic                    reject,
    output logic                    done,
    output logic [2:0]              done_chan,
    output eeprom_pkg::ee_op_t      done_op,
    output logic [`EE_DATA_W-1:0]   rdata,
    output logic                    error
);
    import eeprom_pkg::*;

    logic [`EE_CHANNELS-1:0]                 start;
    logic [`EE_CHANNELS-1:0]                 busy;
    logic [`EE_CHANNELS-1:0]                 fin;
    logic [`EE_CHANNELS-1:0]                 fin_err;
    logic [`EE_CHANNELS-1:0][`EE_DATA_W-1:0] fin_data;
    ee_op_t                                  op;
    logic [`EE_ADDR_W-1:0]                   cmd_addr;
    logic [`EE_DATA_W-1:0]                   cmd_wdata;

    eeprom_cmd_dispatch u_dispatch (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .chan      (chan),
        .addr      (addr),
        .wdata     (wdata),
        .busy      (busy),
        .start     (start),
        .op        (op),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata),
        .reject    (reject)
    );

    // one master per bus
    for (genvar i = 0; i < `EE_CHANNELS; i++)
    begin : g_chan
        eeprom_serial_master u_master (
            .CLK       (CLK),
            .RESET     (RESET),
            .start     (start[i]),
            .op        (op),
            .cmd_addr  (cmd_addr),
            .cmd_wdata (cmd_wdata),
            .sda_in    (sda_in[i]),
            .scl       (scl[i]),
            .sda_low   (sda_low[i]),
            .busy      (busy[i]),
            .fin       (fin[i]),
            .fin_data  (fin_data[i]),
            .fin_err   (fin_err[i])
        );
    end

    eeprom_result_collect u_collect (
        .CLK       (CLK),
        .RESET     (RESET),
        .fin       (fin),
        .fin_data  (fin_data),
        .fin_err   (fin_err),
        .op        (op),
        .busy      (busy),
        .done      (done),
        .done_chan (done_chan),
        .done_op   (done_op),
        .rdata     (rdata),
        .error     (error)
    );

endmodule

/* src/eeprom_result_collect.sv */
`timescale 1ns/1ps
`include "eeprom_defines.svh"

module eeprom_result_collect (
    input  logic                                     CLK,
    input  logic                                     RESET,
    input  logic [`EE_CHANNELS-1:0]                  fin,
    input  logic [`EE_CHANNELS-1:0][`EE_DATA_W-1:0]  fin_data,
    input  logic [`EE_CHANNELS-1:0]                  fin_err,
    input  eeprom_pkg::ee_op_t                       op,
    input  logic [`EE_CHANNELS-1:0]                  busy,
    output logic                                     done,
    output logic [2:0]                               done_chan,
    output eeprom_pkg::ee_op_t                       done_op,
    output logic [`EE_DATA_W-1:0]                    rdata,
    output logic                                     error
);
    import eeprom_pkg::*;

    ee_op_t                  op_q;   // op as it stood in the start cycle
    ee_op_t                  res_op   [`EE_CHANNELS];
    logic [`EE_DATA_W-1:0]   res_data [`EE_CHANNELS];
    logic [`EE_CHANNELS-1:0] res_err;
    logic [`EE_CHANNELS-1:0] pending;
    logic [`EE_CHANNELS-1:0] busy_q;
    logic [1:0]              ptr;
    logic                    found;
    int                      pick;

    // first pending channel at or after ptr
    always_comb
    begin
        found = 1'b0;
        pick  = 0;
        for (int k = 0; k < `EE_CHANNELS; k++)
        begin
            for (int i = 0; i < `EE_CHANNELS; i++)
            begin
                if (!found && pending[i] && i == (int'(ptr) + k) % `EE_CHANNELS)
                begin
                    found = 1'b1;
                    pick  = i;
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            pending <= '0;
            busy_q  <= '0;
            ptr     <= 2'd0;
            done    <= 1'b0;
        end
        else
        begin
            busy_q <= busy;
            done   <= found;
            if (found)
                ptr <= 2'((pick + 1) % `EE_CHANNELS);
            for (int i = 0; i < `EE_CHANNELS; i++)
            begin
                if (found && pick == i)
                    pending[i] <= 1'b0;
                if (fin[i])
                    pending[i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        op_q      <= op;
        done_chan <= 3'(pick);
        for (int i = 0; i < `EE_CHANNELS; i++)
        begin
            if (busy[i] && !busy_q[i])   // transfer just began
                res_op[i] <= op_q;
            if (fin[i])
            begin
                res_data[i] <= fin_data[i];
                res_err[i]  <= fin_err[i];
            end
            if (found && pick == i)
            begin
                done_op <= res_op[i];
                rdata   <= res_data[i];
                error   <= res_err[i];
            end
        end
    end

endmodule

/* src/eeprom_serial_master.sv */
`timescale 1ns/1ps
`include "eeprom_defines.svh"

module eeprom_serial_master (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  start,
    input  eeprom_pkg::ee_op_t    op,
    input  logic [`EE_ADDR_W-1:0] cmd_addr,
    input  logic [`EE_DATA_W-1:0] cmd_wdata,
    input  logic                  sda_in,
    output logic                  scl,
    output logic                  sda_low,
    output logic                  busy,
    output logic                  fin,
    output logic [`EE_DATA_W-1:0] fin_data,
    output logic                  fin_err
);
    import eeprom_pkg::*;

    ee_state_t             st, st_n;
    logic [1:0]            q, q_n;          // quarter within the bit
    logic [7:0]            ph, ph_n;        // cycles within the quarter
    logic [3:0]            bcnt, bcnt_n;    // 8 is the ack slot
    logic [7:0]            sreg, sreg_n;
    logic                  err, err_n;
    logic                  nak, nak_n;
    logic                  tick;
    logic                  tx;
    ee_op_t                op_q;
    logic [`EE_ADDR_W-1:0] addr_q;
    logic [`EE_DATA_W-1:0] wdata_q;

    // {scl, sda_low} for a given state and quarter
    function automatic logic [1:0] bus_drive(ee_state_t s, logic [1:0] qq, logic [3:0] bc,
                                             logic msb);
        logic hi;
        hi = (qq == 2'd1) || (qq == 2'd2);
        case (s)
            st_start:       bus_drive = {qq != 2'd3, qq[1]};   // sda falls with scl high
            st_restart:     bus_drive = {hi, qq[1]};
            st_stop:        bus_drive = {qq != 2'd0, ~qq[1]};  // sda rises with scl high
            st_ctrl_write, st_addr_write, st_data_write, st_ctrl_read:
                bus_drive = {hi, (bc != 4'd8) && !msb};
            st_data_read, st_master_nack:
                bus_drive = {hi, 1'b0};
            default:        bus_drive = 2'b10;
        endcase
    endfunction

    assign tick = (ph == 8'(`EE_PHASE - 1));
    assign tx   = (st == st_ctrl_write) || (st == st_addr_write) ||
                  (st == st_data_write) || (st == st_ctrl_read);

    always_comb
    begin
        st_n   = st;
        q_n    = q;
        ph_n   = ph;
        bcnt_n = bcnt;
        sreg_n = sreg;
        err_n  = err;
        nak_n  = nak;
        if (st == st_idle)
        begin
            if (start)
            begin
                st_n   = st_start;
                q_n    = 2'd0;
                ph_n   = '0;
                bcnt_n = '0;
                err_n  = 1'b0;
                nak_n  = 1'b0;
            end
        end
        else if (st == st_finish)
            st_n = st_idle;
        else if (!tick)
            ph_n = ph + 8'd1;
        else
        begin
            ph_n = '0;
            q_n  = q + 2'd1;
            if (q == 2'd1)
            begin
                // middle of scl high
                if (st == st_data_read)
                    sreg_n = {sreg[6:0], sda_in};
                else if (tx && bcnt == 4'd8)
                    nak_n = sda_in;
            end
            if (q == 2'd3)
            begin
                case (st)
                    st_start:
                    begin
                        st_n   = st_ctrl_write;
                        sreg_n = {4'b1010, addr_q[10:8], 1'b0};
                    end
                    st_restart:
                    begin
                        st_n   = st_ctrl_read;
                        sreg_n = {4'b1010, addr_q[10:8], 1'b1};
                    end
                    st_ctrl_write, st_addr_write, st_data_write, st_ctrl_read:
                    begin
                        if (bcnt != 4'd8)
                        begin
                            bcnt_n = bcnt + 4'd1;
                            sreg_n = {sreg[6:0], 1'b0};
                        end
                        else if (nak)
                        begin
                            // no ack, abort
                            st_n   = st_stop;
                            bcnt_n = '0;
                            err_n  = 1'b1;
                        end
                        else
                        begin
                            bcnt_n = '0;
                            case (st)
                                st_ctrl_write:
                                begin
                                    st_n   = st_addr_write;
                                    sreg_n = addr_q[7:0];
                                end
                                st_addr_write:
                                begin
                                    if (op_q == op_write)
                                    begin
                                        st_n   = st_data_write;
                                        sreg_n = wdata_q;
                                    end
                                    else
                                        st_n = st_restart;
                                end
                                st_ctrl_read:
                                    st_n = st_data_read;
                                default:
                                    st_n = st_stop;
                            endcase
                        end
                    end
                    st_data_read:
                    begin
                        if (bcnt == 4'd7)
                        begin
                            st_n   = st_master_nack;
                            bcnt_n = '0;
                        end
                        else
                            bcnt_n = bcnt + 4'd1;
                    end
                    st_master_nack: st_n = st_stop;
                    st_stop:        st_n = st_finish;
                    default:        st_n = st_idle;
                endcase
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            st      <= st_idle;
            q       <= 2'd0;
            ph      <= '0;
            bcnt    <= '0;
            err     <= 1'b0;
            nak     <= 1'b0;
            scl     <= 1'b1;
            sda_low <= 1'b0;
        end
        else
        begin
            st             <= st_n;
            q              <= q_n;
            ph             <= ph_n;
            bcnt           <= bcnt_n;
            err            <= err_n;
            nak            <= nak_n;
            {scl, sda_low} <= bus_drive(st_n, q_n, bcnt_n, sreg_n[7]);
        end
    end

    always_ff @(posedge CLK)
    begin
        sreg <= sreg_n;
        if (st == st_idle && start)
        begin
            op_q    <= op;
            addr_q  <= cmd_addr;
            wdata_q <= cmd_wdata;
        end
    end

    assign busy     = (st != st_idle);
    assign fin      = (st == st_finish);
    assign fin_data = sreg;   // read byte, last shifted in
    assign fin_err  = err;

endmodule

/* src/eeprom_cmd_dispatch.sv */
`timescale 1ns/1ps
`include "eeprom_defines.svh"

module eeprom_cmd_dispatch (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    wr,
    input  logic                    rd,
    input  logic [2:0]              chan,
    input  logic [`EE_ADDR_W-1:0]   addr,
    input  logic [`EE_DATA_W-1:0]   wdata,
    input  logic [`EE_CHANNELS-1:0] busy,
    output logic [`EE_CHANNELS-1:0] start,
    output eeprom_pkg::ee_op_t      op,
    output logic [`EE_ADDR_W-1:0]   cmd_addr,
    output logic [`EE_DATA_W-1:0]   cmd_wdata,
    output logic                    reject
);
    import eeprom_pkg::*;

    logic                    strobe;
    logic                    in_range;
    logic                    accept;
    logic [`EE_CHANNELS-1:0] sel;

    assign strobe   = wr | rd;
    assign in_range = int'(chan) < `EE_CHANNELS;

    always_comb
    begin
        for (int i = 0; i < `EE_CHANNELS; i++)
            sel[i] = (int'(chan) == i);
    end

    assign accept = strobe && in_range && ((sel & busy) == '0);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            start  <= '0;
            reject <= 1'b0;
        end
        else
        begin
            start  <= accept ? sel : '0;
            reject <= strobe & ~accept;   // busy or bad channel
        end
    end

    // one accept per cycle, so all masters share these
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            op        <= wr ? op_write : op_read;   // wr wins over rd
            cmd_addr  <= addr;
            cmd_wdata <= wdata;
        end
    end

endmodule

/* src/eeprom_pkg.sv */
package eeprom_pkg;

    typedef enum logic {
        op_write = 1'b0,
        op_read  = 1'b1
    } ee_op_t;

    // master sequencer states
    typedef enum logic [3:0] {
        st_idle,
        st_start,
        st_ctrl_write,
        st_addr_write,
        st_data_write,
        st_restart,
        st_ctrl_read,
        st_data_read,
        st_master_nack,
        st_stop,
        st_finish
    } ee_state_t;

endpackage

/* src/eeprom_defines.svh */
`ifndef EEPROM_DEFINES_SVH
`define EEPROM_DEFINES_SVH

// number of independent two-wire buses, 1 to 4
`define EE_CHANNELS 2

`define EE_ADDR_W 11    // 2048-byte device
`define EE_DATA_W 8

// CLK cycles per quarter of a bus bit
`define EE_PHASE 1

`endif
